// ==== mhq.f ====
verilog/mhq_pkg.sv
verilog/mhq_lu.sv
verilog/mhq_ex.sv
verilog/mhq_fill_ctrl.sv
verilog/mhq.sv
tb/ccu_model.sv
tb/tb_mhq.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the miss handling queue testbench with Verilator and run it.
# The exit status is the simulator's, so a failing run returns non-zero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f mhq.f --top-module tb_mhq -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mhq
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit $status
fi
exit 0

// ==== tb/tb_mhq.sv ====
`default_nettype none

module tb_mhq
    import mhq_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS    = 12;
    localparam int MAX_DELAY   = 20;
    localparam int CYCLE_LIMIT = NUM_ROWS * MAX_DELAY + 50;

    // Wait mode before a row is 0 for back to back, 1 for a drained queue
    // and 2 for the cycle in which the CCU answers
    typedef struct {
        int                       wait_mode;
        logic                     dc_hit;
        logic [ADDR_WIDTH-1:0]    addr;
        lsu_func_t                func;
        logic [DATA_WIDTH-1:0]    data;
        int                       delay;
        logic [MHQ_IDX_WIDTH-1:0] exp_tag;
        logic                     exp_retry;
    } row_t;

    row_t rows [NUM_ROWS] = '{
        '{1, 1'b1, 32'h0000_0100, LSU_FUNC_LW, 32'h0000_0000, 3, 2'd0, 1'b0},
        '{1, 1'b0, 32'h0000_1040, LSU_FUNC_LW, 32'h0000_0000, 3, 2'd0, 1'b0},
        '{1, 1'b0, 32'h0000_2004, LSU_FUNC_SW, 32'hdead_beef, 6, 2'd1, 1'b0},
        '{0, 1'b0, 32'h0000_2008, LSU_FUNC_LW, 32'h0000_0000, 6, 2'd1, 1'b0},
        '{0, 1'b0, 32'h0000_200d, LSU_FUNC_SB, 32'h0000_005a, 6, 2'd1, 1'b0},
        '{1, 1'b0, 32'h0000_3000, LSU_FUNC_LW, 32'h0000_0000, 20, 2'd2, 1'b0},
        '{0, 1'b0, 32'h0000_3110, LSU_FUNC_SH, 32'h0000_1234, 20, 2'd3, 1'b0},
        '{0, 1'b0, 32'h0000_3220, LSU_FUNC_LB, 32'h0000_0000, 20, 2'd0, 1'b0},
        '{0, 1'b0, 32'h0000_3330, LSU_FUNC_SW, 32'hcafe_0001, 20, 2'd1, 1'b0},
        '{0, 1'b0, 32'h0000_3440, LSU_FUNC_LW, 32'h0000_0000, 20, 2'd0, 1'b1},
        '{2, 1'b0, 32'h0000_3004, LSU_FUNC_SB, 32'h0000_0077, 20, 2'd0, 1'b1},
        '{1, 1'b1, 32'h0000_0200, LSU_FUNC_LW, 32'h0000_0000, 2, 2'd2, 1'b0}
    };

    logic clk = 1'b0;
    logic i_reset, lk_valid, lk_dc_hit, lk_we;
    logic [ADDR_WIDTH-1:0] lk_addr, fill_addr, ccu_addr;
    lsu_func_t lk_func;
    logic [DATA_WIDTH-1:0] lk_data;
    logic ack, retry, fill_en, fill_dirty, ccu_en, ccu_done, ccu_due;
    logic [MHQ_IDX_WIDTH-1:0] tag, fill_tag, sb_head;
    logic [LINE_WIDTH-1:0] fill_data, ccu_data;
    int ccu_delay;
    int cycles;

    // Scoreboard copy of the queue entries
    logic [MHQ_DEPTH-1:0]             sb_valid;
    logic [ADDR_WIDTH-1:OFFSET_WIDTH] sb_line [MHQ_DEPTH];
    logic [LINE_BYTES-1:0]            sb_mask [MHQ_DEPTH];
    logic [LINE_WIDTH-1:0]            sb_data [MHQ_DEPTH];

    always #50 clk = ~clk;

    mhq dut0 (
        .clk(clk), .i_reset(i_reset),
        .i_mhq_lookup_valid(lk_valid), .i_mhq_lookup_dc_hit(lk_dc_hit),
        .i_mhq_lookup_addr(lk_addr), .i_mhq_lookup_lsu_func(lk_func),
        .i_mhq_lookup_data(lk_data), .i_mhq_lookup_we(lk_we),
        .o_mhq_lookup_ack(ack), .o_mhq_lookup_tag(tag), .o_mhq_lookup_retry(retry),
        .o_mhq_fill_en(fill_en), .o_mhq_fill_tag(fill_tag), .o_mhq_fill_dirty(fill_dirty),
        .o_mhq_fill_addr(fill_addr), .o_mhq_fill_data(fill_data),
        .i_ccu_done(ccu_done), .i_ccu_data(ccu_data), .o_ccu_en(ccu_en), .o_ccu_addr(ccu_addr)
    );

    ccu_model ccu0 (
        .clk(clk), .i_reset(i_reset), .i_ccu_en(ccu_en), .i_ccu_addr(ccu_addr),
        .i_delay(ccu_delay), .o_due(ccu_due), .o_done(ccu_done), .o_data(ccu_data)
    );

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_tag(string name, logic [MHQ_IDX_WIDTH-1:0] act, exp);
        if (act !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act));
        end
    endtask

    task automatic check_retry(string name, logic act, logic exp);
        if (act !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s expected %0b got %0b", $time, name, exp, act));
        end
    endtask

    task automatic check_fill_data(string name, logic [LINE_WIDTH-1:0] act, exp);
        if (act !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_fill_dirty(string name, logic act, logic exp);
        if (act !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s expected %0b got %0b", $time, name, exp, act));
        end
    endtask

    task automatic check_fill_addr(string name, logic [ADDR_WIDTH-1:0] act, exp);
        if (act !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    // Advances one clock cycle and checks the CCU request and any fill against the scoreboard
    task automatic step();
        logic [LINE_WIDTH-1:0] exp_line;
        @(negedge clk);
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            report_failure("Timeout: the run went past its cycle limit");
        end
        if (ccu_en && sb_valid == '0) begin
            report_failure("A CCU request was raised with no miss queued");
        end
        if (ccu_en) begin
            check_fill_addr("o_ccu_addr", ccu_addr, {sb_line[sb_head], 4'h0});
        end
        if (fill_en !== ccu_done) begin
            report_failure("The fill strobe did not come one cycle after CCU done");
        end
        if (fill_en) begin
            if (!sb_valid[sb_head]) begin
                report_failure("A fill came out for an entry that is not queued");
            end
            for (int b = 0; b < LINE_BYTES; b++) begin
                exp_line[b*8 +: 8] = sb_mask[sb_head][b] ? sb_data[sb_head][b*8 +: 8]
                                                         : ccu_data[b*8 +: 8];
            end
            check_tag("o_mhq_fill_tag", fill_tag, sb_head);
            check_fill_addr("o_mhq_fill_addr", fill_addr, {sb_line[sb_head], 4'h0});
            check_fill_data("o_mhq_fill_data", fill_data, exp_line);
            check_fill_dirty("o_mhq_fill_dirty", fill_dirty, |sb_mask[sb_head]);
            sb_valid[sb_head] = 1'b0;
            sb_head++;
        end
    endtask

    task automatic drain_queue();
        while (sb_valid != '0 || ccu_en) begin
            step();
        end
        repeat (3) step();
    endtask

    // Store bytes land at the byte offset, taken from the low end of the data
    task automatic record_store(row_t r, logic [MHQ_IDX_WIDTH-1:0] t);
        int base;
        int nbytes;
        base = r.addr[3:0];
        case (r.func)
            LSU_FUNC_SB: nbytes = 1;
            LSU_FUNC_SH: nbytes = 2;
            LSU_FUNC_SW: nbytes = 4;
            default:     nbytes = 0;
        endcase
        for (int k = 0; k < nbytes; k++) begin
            sb_mask[t][base+k]         = 1'b1;
            sb_data[t][(base+k)*8 +: 8] = r.data[k*8 +: 8];
        end
    endtask

    initial begin
        cycles    = 0;
        sb_valid  = '0;
        sb_head   = '0;
        i_reset   = 1'b1;
        lk_valid  = 1'b0;
        lk_dc_hit = 1'b0;
        lk_we     = 1'b0;
        lk_addr   = '0;
        lk_func   = LSU_FUNC_LW;
        lk_data   = '0;
        ccu_delay = 1;
        repeat (8) @(negedge clk);
        i_reset = 1'b0;
        check_retry("o_mhq_lookup_ack", ack, 1'b0);
        check_retry("o_mhq_lookup_retry", retry, 1'b0);
        check_retry("o_ccu_en", ccu_en, 1'b0);
        check_retry("o_mhq_fill_en", fill_en, 1'b0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].wait_mode == 1) begin
                drain_queue();
            end
            while (rows[i].wait_mode == 2 && !ccu_due) begin
                step();
            end
            // The row's delay governs the CCU request that this lookup can start
            ccu_delay = rows[i].delay;
            lk_valid  = 1'b1;
            lk_dc_hit = rows[i].dc_hit;
            lk_addr   = rows[i].addr;
            lk_func   = rows[i].func;
            lk_data   = rows[i].data;
            lk_we     = rows[i].func[2];
            step();
            lk_valid = 1'b0;
            check_retry("o_mhq_lookup_ack", ack, 1'b1);
            check_retry("o_mhq_lookup_retry", retry, rows[i].exp_retry);
            if (!rows[i].exp_retry && !rows[i].dc_hit) begin
                check_tag("o_mhq_lookup_tag", tag, rows[i].exp_tag);
                // A tag that is not queued yet is a fresh allocation
                if (!sb_valid[rows[i].exp_tag]) begin
                    sb_valid[rows[i].exp_tag] = 1'b1;
                    sb_line[rows[i].exp_tag]  = rows[i].addr[ADDR_WIDTH-1:OFFSET_WIDTH];
                    sb_mask[rows[i].exp_tag]  = '0;
                end
                record_store(rows[i], rows[i].exp_tag);
            end
        end
        drain_queue();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/ccu_model.sv ====
`default_nettype none

module ccu_model
    import mhq_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_ccu_en,
    input  logic [ADDR_WIDTH-1:0] i_ccu_addr,
    input  int                    i_delay,
    output logic                  o_due,
    output logic                  o_done,
    output logic [LINE_WIDTH-1:0] o_data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [LINE_WIDTH-1:0] line_table [0:15];
    logic                  done_q = 1'b0;
    logic [LINE_WIDTH-1:0] data_q = '0;
    int                    wait_cnt = 0;
    int                    seed;

    // Line contents are picked by address bits 7 to 4
    initial begin
        seed = 39;
        for (int i = 0; i < 16; i++) begin
            line_table[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
    end

    // Done becomes due once the request has been held for i_delay falling edges
    assign o_due  = i_ccu_en && !done_q && (wait_cnt >= i_delay);
    assign o_done = done_q;
    assign o_data = data_q;

    always @(negedge clk) begin
        if (i_reset) begin
            done_q   <= 1'b0;
            wait_cnt <= 0;
        end else begin
            done_q   <= o_due;
            wait_cnt <= (i_ccu_en && !done_q && !o_due) ? wait_cnt + 1 : 0;
        end
        data_q <= line_table[i_ccu_addr[7:4]];
    end

endmodule

`default_nettype wire

// ==== verilog/mhq.sv ====
`default_nettype none

module mhq
    import mhq_pkg::*;
(
    input  logic                             clk,
    input  logic                             i_reset,

    // Lookup port from the LSU
    input  logic                             i_mhq_lookup_valid,
    input  logic                             i_mhq_lookup_dc_hit,
    input  logic [ADDR_WIDTH-1:0]            i_mhq_lookup_addr,
    input  lsu_func_t                        i_mhq_lookup_lsu_func,
    input  logic [DATA_WIDTH-1:0]            i_mhq_lookup_data,
    input  logic                             i_mhq_lookup_we,
    output logic                             o_mhq_lookup_ack,
    output logic [MHQ_IDX_WIDTH-1:0]         o_mhq_lookup_tag,
    output logic                             o_mhq_lookup_retry,

    // Line fill towards the data cache
    output logic                             o_mhq_fill_en,
    output logic [MHQ_IDX_WIDTH-1:0]         o_mhq_fill_tag,
    output logic                             o_mhq_fill_dirty,
    output logic [ADDR_WIDTH-1:0]            o_mhq_fill_addr,
    output logic [LINE_WIDTH-1:0]            o_mhq_fill_data,

    // CCU request and response
    input  logic                             i_ccu_done,
    input  logic [LINE_WIDTH-1:0]            i_ccu_data,
    output logic                             o_ccu_en,
    output logic [ADDR_WIDTH-1:0]            o_ccu_addr
);

    logic                             mhq_lu_en;
    logic                             mhq_lu_we;
    logic [OFFSET_WIDTH-1:0]          mhq_lu_offset;
    logic [DATA_WIDTH-1:0]            mhq_lu_wr_data;
    logic [WORD_BYTES-1:0]            mhq_lu_byte_select;
    logic                             mhq_lu_match;
    logic [MHQ_IDX_WIDTH-1:0]         mhq_lu_tag;
    logic [ADDR_WIDTH-1:OFFSET_WIDTH] mhq_lu_addr;
    logic [MHQ_DEPTH-1:0]             mhq_entry_valid;
    logic [ADDR_WIDTH-1:OFFSET_WIDTH] mhq_entry_addr [0:MHQ_DEPTH-1];
    logic [ADDR_WIDTH-1:OFFSET_WIDTH] mhq_head_addr;
    logic [MHQ_IDX_WIDTH-1:0]         mhq_head;
    logic [MHQ_IDX_WIDTH-1:0]         mhq_tail;
    logic                             mhq_full;
    logic                             mhq_fill_block;
    logic                             mhq_free;

    assign o_mhq_lookup_tag = mhq_lu_tag;

    mhq_lu mhq_lu_inst (
        .clk(clk), .i_reset(i_reset),
        .i_lookup_valid(i_mhq_lookup_valid), .i_lookup_dc_hit(i_mhq_lookup_dc_hit),
        .i_lookup_addr(i_mhq_lookup_addr), .i_lookup_lsu_func(i_mhq_lookup_lsu_func),
        .i_lookup_data(i_mhq_lookup_data), .i_lookup_we(i_mhq_lookup_we),
        .i_entry_valid(mhq_entry_valid), .i_entry_addr(mhq_entry_addr),
        .i_tail(mhq_tail), .i_full(mhq_full),
        .i_fill_busy_line(mhq_head_addr), .i_fill_block(mhq_fill_block),
        .i_ex_en(mhq_lu_en), .i_ex_addr(mhq_lu_addr), .i_ex_tag(mhq_lu_tag),
        .o_lu_en(mhq_lu_en), .o_lu_we(mhq_lu_we), .o_lu_offset(mhq_lu_offset),
        .o_lu_wr_data(mhq_lu_wr_data), .o_lu_byte_select(mhq_lu_byte_select),
        .o_lu_match(mhq_lu_match), .o_lu_tag(mhq_lu_tag), .o_lu_addr(mhq_lu_addr),
        .o_lu_ack(o_mhq_lookup_ack), .o_lu_retry(o_mhq_lookup_retry)
    );

    mhq_ex mhq_ex_inst (
        .clk(clk), .i_reset(i_reset),
        .i_lu_en(mhq_lu_en), .i_lu_we(mhq_lu_we), .i_lu_offset(mhq_lu_offset),
        .i_lu_wr_data(mhq_lu_wr_data), .i_lu_byte_select(mhq_lu_byte_select),
        .i_lu_match(mhq_lu_match), .i_lu_tag(mhq_lu_tag), .i_lu_addr(mhq_lu_addr),
        .i_head(mhq_head), .i_ccu_done(i_ccu_done), .i_ccu_data(i_ccu_data),
        .i_free(mhq_free),
        .o_entry_valid(mhq_entry_valid), .o_entry_addr(mhq_entry_addr),
        .o_head_addr(mhq_head_addr), .o_fill_data(o_mhq_fill_data),
        .o_fill_dirty(o_mhq_fill_dirty), .o_fill_addr(o_mhq_fill_addr)
    );

    mhq_fill_ctrl mhq_fill_ctrl_inst (
        .clk(clk), .i_reset(i_reset),
        .i_lu_en(mhq_lu_en), .i_lu_match(mhq_lu_match),
        .i_head_valid(mhq_entry_valid[mhq_head]), .i_head_addr(mhq_head_addr),
        .i_ccu_done(i_ccu_done),
        .o_head(mhq_head), .o_tail(mhq_tail), .o_full(mhq_full),
        .o_ccu_en(o_ccu_en), .o_ccu_addr(o_ccu_addr), .o_fill_block(mhq_fill_block),
        .o_free(mhq_free), .o_fill_en(o_mhq_fill_en), .o_fill_tag(o_mhq_fill_tag)
    );

endmodule

`default_nettype wire

// ==== verilog/mhq_fill_ctrl.sv ====
`default_nettype none

module mhq_fill_ctrl
    import mhq_pkg::*;
(
    input  logic                             clk,
    input  logic                             i_reset,

    // Execute stage activity
    input  logic                             i_lu_en,
    input  logic                             i_lu_match,

    // Head entry state
    input  logic                             i_head_valid,
    input  logic [ADDR_WIDTH-1:OFFSET_WIDTH] i_head_addr,

    input  logic                             i_ccu_done,

    output logic [MHQ_IDX_WIDTH-1:0]         o_head,
    output logic [MHQ_IDX_WIDTH-1:0]         o_tail,
    output logic                             o_full,
    output logic                             o_ccu_en,
    output logic [ADDR_WIDTH-1:0]            o_ccu_addr,
    output logic                             o_fill_block,
    output logic                             o_free,
    output logic                             o_fill_en,
    output logic [MHQ_IDX_WIDTH-1:0]         o_fill_tag
);

    fill_state_t              state;
    fill_state_t              state_next;
    logic [MHQ_IDX_WIDTH-1:0] head;
    logic [MHQ_IDX_WIDTH-1:0] tail;
    logic [MHQ_IDX_WIDTH:0]   count;
    logic                     alloc;
    logic                     free;

    assign alloc = i_lu_en && !i_lu_match;
    assign free  = (state == FILL_DONE);

    // With nothing pending, an allocation always lands on the head slot,
    // so the request can start right after it is written
    always_comb begin
        state_next = state;
        case (state)
            FILL_IDLE: begin
                if (i_head_valid || alloc) begin
                    state_next = FILL_BUSY;
                end
            end
            FILL_BUSY: begin
                if (i_ccu_done) begin
                    state_next = FILL_DONE;
                end
            end
            default: begin
                state_next = FILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= FILL_IDLE;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            state <= state_next;
            if (free) begin
                head <= head + 1'b1;
            end
            if (alloc) begin
                tail <= tail + 1'b1;
            end
            count <= count + (MHQ_IDX_WIDTH+1)'(alloc) - (MHQ_IDX_WIDTH+1)'(free);
        end
    end

    assign o_head = head;

    // Slot for the next lookup, stepping past an allocation still in flight
    assign o_tail = tail + MHQ_IDX_WIDTH'(alloc);
    assign o_full = (count == MHQ_DEPTH) || (alloc && (count == MHQ_DEPTH - 1));

    assign o_ccu_en     = (state == FILL_BUSY);
    assign o_ccu_addr   = {i_head_addr, {OFFSET_WIDTH{1'b0}}};
    assign o_fill_block = free || i_ccu_done;
    assign o_free       = free;
    assign o_fill_en    = free;
    assign o_fill_tag   = head;

    // The CCU only answers a request that is being held
    assert property (@(posedge clk) disable iff (i_reset)
        i_ccu_done |-> (state == FILL_BUSY));

    assert property (@(posedge clk) disable iff (i_reset)
        count <= MHQ_DEPTH);

endmodule

`default_nettype wire

// ==== verilog/mhq_ex.sv ====
`default_nettype none

module mhq_ex
    import mhq_pkg::*;
(
    input  logic                             clk,
    input  logic                             i_reset,

    // Registered request from the lookup stage
    input  logic                             i_lu_en,
    input  logic                             i_lu_we,
    input  logic [OFFSET_WIDTH-1:0]          i_lu_offset,
    input  logic [DATA_WIDTH-1:0]            i_lu_wr_data,
    input  logic [WORD_BYTES-1:0]            i_lu_byte_select,
    input  logic                             i_lu_match,
    input  logic [MHQ_IDX_WIDTH-1:0]         i_lu_tag,
    input  logic [ADDR_WIDTH-1:OFFSET_WIDTH] i_lu_addr,

    // Head entry handling
    input  logic [MHQ_IDX_WIDTH-1:0]         i_head,
    input  logic                             i_ccu_done,
    input  logic [LINE_WIDTH-1:0]            i_ccu_data,
    input  logic                             i_free,

    output logic [MHQ_DEPTH-1:0]             o_entry_valid,
    output logic [ADDR_WIDTH-1:OFFSET_WIDTH] o_entry_addr [0:MHQ_DEPTH-1],
    output logic [ADDR_WIDTH-1:OFFSET_WIDTH] o_head_addr,
    output logic [LINE_WIDTH-1:0]            o_fill_data,
    output logic                             o_fill_dirty,
    output logic [ADDR_WIDTH-1:0]            o_fill_addr
);

    logic [MHQ_DEPTH-1:0]             entry_valid;
    logic [ADDR_WIDTH-1:OFFSET_WIDTH] entry_addr [0:MHQ_DEPTH-1];
    logic [LINE_WIDTH-1:0]            entry_data [0:MHQ_DEPTH-1];
    logic [LINE_BYTES-1:0]            entry_mask [0:MHQ_DEPTH-1];

    logic [OFFSET_WIDTH-3:0]          word_idx;
    logic [LINE_BYTES-1:0]            wr_mask;
    logic [LINE_WIDTH-1:0]            wr_line;
    logic                             wr_head;
    logic [LINE_BYTES-1:0]            head_mask;
    logic [LINE_WIDTH-1:0]            head_data;
    logic [LINE_WIDTH-1:0]            merged_line;

    // Place the word lanes of the request inside the line
    assign word_idx = i_lu_offset[OFFSET_WIDTH-1:2];
    assign wr_mask  = i_lu_we ? (LINE_BYTES'(i_lu_byte_select) << (word_idx * WORD_BYTES)) : '0;
    assign wr_line  = LINE_WIDTH'(i_lu_wr_data) << (word_idx * DATA_WIDTH);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            entry_valid <= '0;
        end else begin
            if (i_free) begin
                entry_valid[i_head] <= 1'b0;
            end
            if (i_lu_en && !i_lu_match) begin
                entry_valid[i_lu_tag] <= 1'b1;
            end
        end
    end

    // A new entry starts from the request's own mask, a merge adds to it
    always_ff @(posedge clk) begin
        if (i_lu_en) begin
            if (i_lu_match) begin
                entry_mask[i_lu_tag] <= entry_mask[i_lu_tag] | wr_mask;
            end else begin
                entry_addr[i_lu_tag] <= i_lu_addr;
                entry_mask[i_lu_tag] <= wr_mask;
            end
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_mask[b]) begin
                    entry_data[i_lu_tag][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
        end
    end

    // Head line as it will look after this cycle's write, so that a store
    // landing together with the CCU data still makes it into the fill
    assign wr_head = i_lu_en && (i_lu_tag == i_head);

    always_comb begin
        head_mask = entry_mask[i_head];
        head_data = entry_data[i_head];
        if (wr_head) begin
            head_mask = (i_lu_match ? entry_mask[i_head] : '0) | wr_mask;
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_mask[b]) begin
                    head_data[b*8 +: 8] = wr_line[b*8 +: 8];
                end
            end
        end
    end

    // Stored bytes take priority over the line from memory
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            merged_line[b*8 +: 8] = head_mask[b] ? head_data[b*8 +: 8] : i_ccu_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (i_ccu_done) begin
            o_fill_data  <= merged_line;
            o_fill_dirty <= |head_mask;
            o_fill_addr  <= {entry_addr[i_head], {OFFSET_WIDTH{1'b0}}};
        end
    end

    assign o_entry_valid = entry_valid;
    assign o_entry_addr  = entry_addr;
    assign o_head_addr   = entry_addr[i_head];

    // The tail handed out by the lookup stage must always point at a free slot
    assert property (@(posedge clk) disable iff (i_reset)
        (i_lu_en && !i_lu_match) |-> !entry_valid[i_lu_tag]);

endmodule

`default_nettype wire

// ==== verilog/mhq_lu.sv ====
`default_nettype none

module mhq_lu
    import mhq_pkg::*;
(
    input  logic                             clk,
    input  logic                             i_reset,

    // Lookup request from the LSU
    input  logic                             i_lookup_valid,
    input  logic                             i_lookup_dc_hit,
    input  logic [ADDR_WIDTH-1:0]            i_lookup_addr,
    input  lsu_func_t                        i_lookup_lsu_func,
    input  logic [DATA_WIDTH-1:0]            i_lookup_data,
    input  logic                             i_lookup_we,

    // Entry state for the CAM and the allocation decision
    input  logic [MHQ_DEPTH-1:0]             i_entry_valid,
    input  logic [ADDR_WIDTH-1:OFFSET_WIDTH] i_entry_addr [0:MHQ_DEPTH-1],
    input  logic [MHQ_IDX_WIDTH-1:0]         i_tail,
    input  logic                             i_full,
    input  logic [ADDR_WIDTH-1:OFFSET_WIDTH] i_fill_busy_line,
    input  logic                             i_fill_block,

    // Request sitting in the execute stage this cycle
    input  logic                             i_ex_en,
    input  logic [ADDR_WIDTH-1:OFFSET_WIDTH] i_ex_addr,
    input  logic [MHQ_IDX_WIDTH-1:0]         i_ex_tag,

    output logic                             o_lu_en,
    output logic                             o_lu_we,
    output logic [OFFSET_WIDTH-1:0]          o_lu_offset,
    output logic [DATA_WIDTH-1:0]            o_lu_wr_data,
    output logic [WORD_BYTES-1:0]            o_lu_byte_select,
    output logic                             o_lu_match,
    output logic [MHQ_IDX_WIDTH-1:0]         o_lu_tag,
    output logic [ADDR_WIDTH-1:OFFSET_WIDTH] o_lu_addr,
    output logic                             o_lu_ack,
    output logic                             o_lu_retry
);

    logic [ADDR_WIDTH-1:OFFSET_WIDTH] lookup_line;
    logic [OFFSET_WIDTH-1:0]          lookup_offset;
    logic [MHQ_DEPTH-1:0]             entry_match;
    logic                             bypass_match;
    logic                             any_match;
    logic [MHQ_IDX_WIDTH-1:0]         match_tag;
    logic                             head_blocked;
    logic                             miss;
    logic                             retry;
    logic [WORD_BYTES-1:0]            byte_select;
    logic [DATA_WIDTH-1:0]            wr_data;

    assign lookup_line   = i_lookup_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    assign lookup_offset = i_lookup_addr[OFFSET_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            entry_match[i] = i_entry_valid[i] && (i_entry_addr[i] == lookup_line);
        end
    end

    // The entry being allocated right now is not valid yet, so it is only seen here
    assign bypass_match = i_ex_en && (i_ex_addr == lookup_line);
    assign any_match    = bypass_match || (|entry_match);

    // Without a match the request takes the slot at the tail
    always_comb begin
        match_tag = i_tail;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (entry_match[i]) begin
                match_tag = MHQ_IDX_WIDTH'(i);
            end
        end
        if (bypass_match) begin
            match_tag = i_ex_tag;
        end
    end

    // A line whose fill is already captured can no longer take new bytes
    assign head_blocked = i_fill_block && (lookup_line == i_fill_busy_line);
    assign miss         = i_lookup_valid && !i_lookup_dc_hit;
    assign retry        = miss && ((!any_match && i_full) || head_blocked);

    // Byte lanes within the addressed word
    always_comb begin
        case (i_lookup_lsu_func)
            LSU_FUNC_LB, LSU_FUNC_SB: byte_select = WORD_BYTES'(1) << lookup_offset[1:0];
            LSU_FUNC_LH, LSU_FUNC_SH: byte_select = WORD_BYTES'(3) << lookup_offset[1:0];
            default:                  byte_select = '1;
        endcase
    end

    // Store data arrives right aligned and is moved onto its byte lanes
    assign wr_data = i_lookup_data << {lookup_offset[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_lu_en    <= 1'b0;
            o_lu_ack   <= 1'b0;
            o_lu_retry <= 1'b0;
        end else begin
            o_lu_en    <= miss && !retry;
            o_lu_ack   <= i_lookup_valid;
            o_lu_retry <= retry;
        end
    end

    always_ff @(posedge clk) begin
        o_lu_we          <= i_lookup_we;
        o_lu_offset      <= lookup_offset;
        o_lu_wr_data     <= wr_data;
        o_lu_byte_select <= byte_select;
        o_lu_match       <= any_match;
        o_lu_tag         <= match_tag;
        o_lu_addr        <= lookup_line;
    end

    // Each line lives in one entry at most, otherwise merging would split a line
    assert property (@(posedge clk) disable iff (i_reset)
        i_lookup_valid |-> $onehot0(entry_match));

endmodule

`default_nettype wire

// ==== verilog/mhq_pkg.sv ====
`default_nettype none

package mhq_pkg;

    // Queue geometry
    localparam int MHQ_DEPTH     = 4;
    localparam int MHQ_IDX_WIDTH = 2;

    // Widths seen by the LSU
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int WORD_BYTES = 4;

    // Data cache line geometry with the line address in ADDR_WIDTH-1 down to OFFSET_WIDTH
    localparam int LINE_BYTES   = 16;
    localparam int LINE_WIDTH   = 128;
    localparam int OFFSET_WIDTH = 4;

    // Memory operations issued by the LSU
    // Only the store encodings put bytes into an entry
    typedef enum logic [2:0] {
        LSU_FUNC_LB = 3'b000,
        LSU_FUNC_LH = 3'b001,
        LSU_FUNC_LW = 3'b010,
        LSU_FUNC_SB = 3'b100,
        LSU_FUNC_SH = 3'b101,
        LSU_FUNC_SW = 3'b110
    } lsu_func_t;

    // The fill controller works on the head entry only
    // BUSY holds the CCU request and DONE is the single fill cycle
    typedef enum logic [1:0] {
        FILL_IDLE = 2'b00,
        FILL_BUSY = 2'b01,
        FILL_DONE = 2'b10
    } fill_state_t;

endpackage

`default_nettype wire
